// ==== common/fe_params.svh ====
`ifndef FE_PARAMS_SVH
`define FE_PARAMS_SVH

// Address and instruction word width
`define FE_XLEN 32

// BTB index bits, 2**FE_BTB_IDX direct-mapped entries
`define FE_BTB_IDX 4

// Return address stack entries
`define FE_RAS_DEPTH 4

`endif

// ==== common/fe_pkg.sv ====
`include "fe_params.svh"

package fe_pkg;

    typedef logic [`FE_XLEN-1:0] u32_t;

    // Next PC as seen by the front end, is_predict set when a predictor supplied it
    typedef struct packed {
        u32_t pc;
        logic is_predict;
    } next_pc_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
    } imem_req_t;

    typedef struct packed {
        logic valid;
        u32_t inst;
    } imem_rsp_t;

    typedef struct packed {
        logic     valid;
        u32_t     pc;
        next_pc_t next;
    } f1_f2_t;

    typedef struct packed {
        u32_t     pc;
        u32_t     inst;
        next_pc_t next;
    } fetch_pkt_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
    } redirect_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
        u32_t target;
        logic inval;
    } btb_wr_t;

    // Predecode class of a fetched word
    typedef enum logic [2:0] {
        BR_NONE,
        BR_B,
        BR_BL,
        BR_COND,
        BR_JIRL,
        BR_RET
    } br_kind_e;

endpackage

// ==== bpred/btb.sv ====
`timescale 1ns/10ps
`include "fe_params.svh"

module btb import fe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  u32_t     rd_pc_i,
    input  btb_wr_t  wr_i,
    output next_pc_t pred_o
);

    localparam int IDX_W   = `FE_BTB_IDX;
    localparam int ENTRIES = 1 << IDX_W;
    localparam int TAG_W   = `FE_XLEN - IDX_W - 2;

    logic [ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]   tag_q [ENTRIES];
    u32_t               target_q [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [TAG_W-1:0] wr_tag;
    logic             hit;

    // Word aligned PCs, bits 1:0 are not part of index or tag
    assign rd_idx = rd_pc_i[IDX_W+1:2];
    assign rd_tag = rd_pc_i[`FE_XLEN-1:IDX_W+2];
    assign wr_idx = wr_i.pc[IDX_W+1:2];
    assign wr_tag = wr_i.pc[`FE_XLEN-1:IDX_W+2];

    assign hit               = valid_q[rd_idx] & (tag_q[rd_idx] == rd_tag);
    assign pred_o.pc         = hit ? target_q[rd_idx] : rd_pc_i + 32'd4;
    assign pred_o.is_predict = hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_i.valid) begin
            valid_q[wr_idx] <= ~wr_i.inval;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.valid && !wr_i.inval) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= wr_i.target;
        end
    end

endmodule

// ==== bpred/ras.sv ====
`timescale 1ns/10ps
`include "fe_params.svh"

module ras import fe_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic push_i,
    input  u32_t push_addr_i,
    input  logic pop_i,
    input  logic clear_i,
    output u32_t top_o,
    output logic valid_o
);

    localparam int DEPTH = `FE_RAS_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    u32_t             stack_q [DEPTH];
    logic [PTR_W-1:0] top_q;
    logic [PTR_W-1:0] top_inc;
    logic [PTR_W-1:0] top_dec;
    logic [CNT_W-1:0] cnt_q;

    // Pointer wraps around the ring
    assign top_inc = (top_q == PTR_W'(DEPTH - 1)) ? '0 : top_q + 1'b1;
    assign top_dec = (top_q == '0) ? PTR_W'(DEPTH - 1) : top_q - 1'b1;

    assign top_o   = stack_q[top_q];
    assign valid_o = (cnt_q != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            top_q <= '0;
            cnt_q <= '0;
        end else if (clear_i) begin
            cnt_q <= '0;
        end else if (push_i && !pop_i) begin
            // A full stack loses its oldest entry
            top_q <= top_inc;
            if (cnt_q != CNT_W'(DEPTH)) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end else if (pop_i && !push_i && cnt_q != '0) begin
            top_q <= top_dec;
            cnt_q <= cnt_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!clear_i) begin
            if (push_i && pop_i) begin
                // Replace the top in place
                stack_q[top_q] <= push_addr_i;
            end else if (push_i) begin
                stack_q[top_inc] <= push_addr_i;
            end
        end
    end

endmodule

// ==== design/pc_gen.sv ====
`timescale 1ns/10ps

module pc_gen import fe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      imem_req_ready_i,
    input  redirect_t be_redirect_i,
    input  redirect_t f2_redirect_i,
    input  next_pc_t  btb_pred_i,
    input  logic      f2_free_i,
    output imem_req_t imem_req_o,
    output u32_t      btb_pc_o,
    output f1_f2_t    f1_o
);

    localparam u32_t RESET_PC = 32'h0000_1000;

    u32_t pc_q;
    u32_t pc_d;
    logic run_q;
    logic req_fire;

    // Fetch starts one cycle after reset is released
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    // No request while a redirect is about to replace the PC
    assign imem_req_o.valid = run_q & f2_free_i & ~be_redirect_i.valid
                            & ~f2_redirect_i.valid;
    assign imem_req_o.pc    = pc_q;
    assign req_fire         = imem_req_o.valid & imem_req_ready_i;

    // BTB looks up the PC currently held
    assign btb_pc_o = pc_q;

    // Item handed to stage 2 together with the request
    assign f1_o.valid = req_fire;
    assign f1_o.pc    = pc_q;
    assign f1_o.next  = btb_pred_i;

    always_comb begin
        pc_d = pc_q;
        if (be_redirect_i.valid) begin
            pc_d = be_redirect_i.pc;
        end else if (f2_redirect_i.valid) begin
            pc_d = f2_redirect_i.pc;
        end else if (req_fire) begin
            // BTB gives PC + 4 on a miss
            pc_d = btb_pred_i.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

endmodule

// ==== design/fetch2_check.sv ====
`timescale 1ns/10ps

module fetch2_check import fe_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  f1_f2_t     f1_i,
    input  imem_rsp_t  imem_rsp_i,
    input  logic       dec_ready_i,
    input  redirect_t  be_redirect_i,
    input  u32_t       ras_top_i,
    input  logic       ras_valid_i,
    output logic       f2_free_o,
    output fetch_pkt_t dec_o,
    output logic       dec_valid_o,
    output redirect_t  f2_redirect_o,
    output btb_wr_t    btb_wr_o,
    output logic       ras_push_o,
    output logic       ras_pop_o,
    output u32_t       ras_addr_o,
    output logic       ras_clear_o
);

    localparam logic [5:0] OP_JIRL   = 6'b010011;
    localparam logic [5:0] OP_B      = 6'b010100;
    localparam logic [5:0] OP_BL     = 6'b010101;
    localparam logic [5:0] OP_BCC_LO = 6'b010110;
    localparam logic [5:0] OP_BCC_HI = 6'b011011;

    f1_f2_t   f2_q;
    u32_t     inst_q;
    logic     have_q;
    logic     drop_q;
    logic     dec_fire;
    br_kind_e kind;
    u32_t     seq_pc;
    u32_t     br_target;
    logic     take_br;
    logic     take_ret;
    logic     bad_pred;
    logic     need_redir;
    u32_t     redir_pc;
    next_pc_t next_fix;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            f2_q.valid <= 1'b0;
            have_q     <= 1'b0;
            drop_q     <= 1'b0;
        end else if (be_redirect_i.valid) begin
            f2_q.valid <= 1'b0;
            have_q     <= 1'b0;
            // Response still owed for the flushed item gets swallowed later
            drop_q     <= (drop_q | (f2_q.valid & ~have_q)) & ~imem_rsp_i.valid;
        end else begin
            if (dec_fire) begin
                f2_q.valid <= 1'b0;
                have_q     <= 1'b0;
            end
            if (f1_i.valid) begin
                f2_q   <= f1_i;
                have_q <= 1'b0;
            end
            if (imem_rsp_i.valid) begin
                if (drop_q) begin
                    drop_q <= 1'b0;
                end else begin
                    have_q <= 1'b1;
                    inst_q <= imem_rsp_i.inst;
                end
            end
        end
    end

    // Predecode on the opcode field
    always_comb begin
        case (inst_q[31:26]) inside
            OP_JIRL: begin
                kind = (inst_q[4:0] == 5'd0 && inst_q[9:5] == 5'd1) ? BR_RET : BR_JIRL;
            end
            OP_B:                   kind = BR_B;
            OP_BL:                  kind = BR_BL;
            [OP_BCC_LO:OP_BCC_HI]:  kind = BR_COND;
            default:                kind = BR_NONE;
        endcase
    end

    assign seq_pc    = f2_q.pc + 32'd4;
    assign br_target = f2_q.pc + {{4{inst_q[9]}}, inst_q[9:0], inst_q[25:10], 2'b00};
    assign take_br   = (kind == BR_B) | (kind == BR_BL);
    assign take_ret  = (kind == BR_RET) & ras_valid_i;
    // Anything not resolved here must fall through
    assign bad_pred  = ~take_br & ~take_ret & f2_q.next.is_predict
                     & (f2_q.next.pc != seq_pc);

    always_comb begin
        need_redir = 1'b0;
        redir_pc   = seq_pc;
        next_fix   = f2_q.next;
        if (take_br) begin
            need_redir = (f2_q.next.pc != br_target);
            redir_pc   = br_target;
        end else if (take_ret) begin
            need_redir = (f2_q.next.pc != ras_top_i);
            redir_pc   = ras_top_i;
        end else if (bad_pred) begin
            need_redir = 1'b1;
        end
        if (need_redir) begin
            next_fix.pc         = redir_pc;
            next_fix.is_predict = take_ret;
        end
    end

    assign dec_valid_o = f2_q.valid & have_q & ~be_redirect_i.valid;
    assign dec_fire    = dec_valid_o & dec_ready_i;
    assign dec_o.pc    = f2_q.pc;
    assign dec_o.inst  = inst_q;
    assign dec_o.next  = next_fix;

    assign f2_free_o = ~drop_q & (~f2_q.valid | dec_fire);

    // All predictor updates happen on the decode transfer only
    assign f2_redirect_o.valid = dec_fire & need_redir;
    assign f2_redirect_o.pc    = redir_pc;

    assign btb_wr_o.valid  = dec_fire & (take_br | bad_pred);
    assign btb_wr_o.pc     = f2_q.pc;
    assign btb_wr_o.target = br_target;
    assign btb_wr_o.inval  = bad_pred;

    assign ras_push_o  = dec_fire & (kind == BR_BL);
    assign ras_pop_o   = dec_fire & take_ret;
    assign ras_addr_o  = seq_pc;
    assign ras_clear_o = be_redirect_i.valid;

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top import fe_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       imem_req_ready_i,
    input  imem_rsp_t  imem_rsp_i,
    input  logic       dec_ready_i,
    input  redirect_t  be_redirect_i,
    output imem_req_t  imem_req_o,
    output fetch_pkt_t dec_o,
    output logic       dec_valid_o
);

    redirect_t f2_redirect;
    next_pc_t  btb_pred;
    u32_t      btb_pc;
    btb_wr_t   btb_wr;
    f1_f2_t    f1_f2;
    logic      f2_free;
    logic      ras_push;
    logic      ras_pop;
    logic      ras_clear;
    u32_t      ras_addr;
    u32_t      ras_top;
    logic      ras_valid;

    pc_gen u_pc_gen (
        .clk              (clk),
        .rst_n            (rst_n),
        .imem_req_ready_i (imem_req_ready_i),
        .be_redirect_i    (be_redirect_i),
        .f2_redirect_i    (f2_redirect),
        .btb_pred_i       (btb_pred),
        .f2_free_i        (f2_free),
        .imem_req_o       (imem_req_o),
        .btb_pc_o         (btb_pc),
        .f1_o             (f1_f2)
    );

    btb u_btb (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_pc_i (btb_pc),
        .wr_i    (btb_wr),
        .pred_o  (btb_pred)
    );

    ras u_ras (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (ras_push),
        .push_addr_i (ras_addr),
        .pop_i       (ras_pop),
        .clear_i     (ras_clear),
        .top_o       (ras_top),
        .valid_o     (ras_valid)
    );

    fetch2_check u_fetch2_check (
        .clk           (clk),
        .rst_n         (rst_n),
        .f1_i          (f1_f2),
        .imem_rsp_i    (imem_rsp_i),
        .dec_ready_i   (dec_ready_i),
        .be_redirect_i (be_redirect_i),
        .ras_top_i     (ras_top),
        .ras_valid_i   (ras_valid),
        .f2_free_o     (f2_free),
        .dec_o         (dec_o),
        .dec_valid_o   (dec_valid_o),
        .f2_redirect_o (f2_redirect),
        .btb_wr_o      (btb_wr),
        .ras_push_o    (ras_push),
        .ras_pop_o     (ras_pop),
        .ras_addr_o    (ras_addr),
        .ras_clear_o   (ras_clear)
    );

endmodule

// ==== tb/fetch_props.sv ====
`timescale 1ns/10ps

module fetch_props import fe_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input fetch_pkt_t dec_o,
    input logic       dec_valid_o,
    input logic       dec_ready_i,
    input redirect_t  f2_redirect_o
);

    int unsigned err_cnt = 0;

    // Stalled packet keeps its contents
    assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid_o && !dec_ready_i |=> $stable(dec_o))
    else begin
        err_cnt++;
        $error("decode packet changed while stalled");
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        f2_redirect_o.valid |-> dec_valid_o && dec_ready_i)
    else begin
        err_cnt++;
        $error("stage 2 redirect without a decode transfer");
    end

endmodule

bind fetch2_check fetch_props props0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .dec_o         (dec_o),
    .dec_valid_o   (dec_valid_o),
    .dec_ready_i   (dec_ready_i),
    .f2_redirect_o (f2_redirect_o)
);

// ==== tb/fetch_tb.sv ====
`timescale 1ns/10ps
`include "fe_params.svh"

module fetch_tb import fe_pkg::*; ();

    localparam int   NUM_PKTS  = 2000;
    localparam int   STALL_MAX = 300;
    localparam int   BTB_N     = 1 << `FE_BTB_IDX;
    localparam u32_t BASE_PC   = 32'h0000_1000;

    // LoongArch major opcodes used by the program generator and the model
    localparam logic [5:0] OP_JIRL = 6'b010011;
    localparam logic [5:0] OP_B    = 6'b010100;
    localparam logic [5:0] OP_BL   = 6'b010101;

    logic       clk;
    logic       rst_n;
    logic       req_ready;
    imem_rsp_t  imem_rsp;
    logic       dec_ready;
    redirect_t  be_redirect;
    imem_req_t  imem_req;
    fetch_pkt_t dec_pkt;
    logic       dec_valid;

    u32_t      prog [256];
    u32_t      model_ras [$];
    logic      model_btb_valid [BTB_N];
    u32_t      model_btb_pc [BTB_N];
    u32_t      model_btb_tgt [BTB_N];
    u32_t      model_pc;
    u32_t      seed;
    logic      pend;
    u32_t      pend_word;
    int        pend_cnt;
    logic      held;
    imem_req_t held_req;
    logic      first_seen;
    logic      after_redir;
    logic      dec_fire;
    int        pkt_cnt;
    int        rsp_cnt;
    int        stall;

    fetch_top dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .imem_req_ready_i (req_ready),
        .imem_rsp_i       (imem_rsp),
        .dec_ready_i      (dec_ready),
        .be_redirect_i    (be_redirect),
        .imem_req_o       (imem_req),
        .dec_o            (dec_pkt),
        .dec_valid_o      (dec_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic u32_t xorshift(u32_t s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic u32_t rand_word();
        seed = xorshift(seed);
        return seed;
    endfunction

    function automatic logic is_return(u32_t inst);
        return inst[31:26] == OP_JIRL && inst[9:5] == 5'd1 && inst[4:0] == 5'd0;
    endfunction

    // Short nonzero offsets counted in words
    function automatic u32_t branch_word(logic [5:0] op);
        int          off;
        logic [25:0] o;
        off = int'(rand_word() % 48) - 24;
        if (off == 0) begin
            off = 1;
        end
        o = 26'(off);
        return {op, o[15:0], o[25:16]};
    endfunction

    function automatic u32_t gen_word();
        u32_t r;
        r = rand_word();
        case (r[2:0])
            3'd0:    return branch_word(OP_B);
            3'd1:    return branch_word(OP_BL);
            3'd2:    return {6'(22 + int'(r[10:8]) % 6), r[25:0]};
            3'd3:    return {OP_JIRL, r[31:16], 5'd1, 5'd0};
            // JIRL with rd 3 is never a return
            3'd4:    return {OP_JIRL, r[31:16], r[15:11], 5'd3};
            default: return {6'(int'(r[31:27]) % 19), r[25:0]};
        endcase
    endfunction

    function automatic u32_t arch_next(u32_t pc, u32_t inst);
        logic [25:0] off;
        off = {inst[9:0], inst[25:10]};
        if (inst[31:26] == OP_B || inst[31:26] == OP_BL) begin
            return pc + {{4{off[25]}}, off, 2'b00};
        end
        if (is_return(inst) && model_ras.size() != 0) begin
            return model_ras[$];
        end
        return pc + 32'd4;
    endfunction

    task automatic update_ras(u32_t pc, u32_t inst);
        if (inst[31:26] == OP_BL) begin
            model_ras.push_back(pc + 32'd4);
            if (model_ras.size() > `FE_RAS_DEPTH) begin
                void'(model_ras.pop_front());
            end
        end else if (is_return(inst) && model_ras.size() != 0) begin
            void'(model_ras.pop_back());
        end
    endtask

    // True when the direct-mapped BTB holds the right next PC for this PC
    function automatic logic predicted_by_btb(u32_t pc, u32_t next);
        int i;
        i = int'(pc[`FE_BTB_IDX+1:2]);
        return model_btb_valid[i] && model_btb_pc[i] == pc && model_btb_tgt[i] == next;
    endfunction

    // B and BL train their entry, a wrong taken hit on anything else is dropped
    task automatic train_btb(u32_t pc, u32_t inst, logic ret_taken);
        int i;
        i = int'(pc[`FE_BTB_IDX+1:2]);
        if (inst[31:26] == OP_B || inst[31:26] == OP_BL) begin
            model_btb_valid[i] = 1'b1;
            model_btb_pc[i]    = pc;
            model_btb_tgt[i]   = arch_next(pc, inst);
        end else if (!ret_taken && model_btb_valid[i] && model_btb_pc[i] == pc
                     && model_btb_tgt[i] != pc + 32'd4) begin
            model_btb_valid[i] = 1'b0;
        end
    endtask

    task automatic stop_failed();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic string pkt_text(fetch_pkt_t p);
        return $sformatf("pc=%h inst=%h next=%h pred=%b", p.pc, p.inst, p.next.pc,
                         p.next.is_predict);
    endfunction

    task automatic check_pkt(string name, fetch_pkt_t exp, fetch_pkt_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %s, actual %s",
                     name, pkt_text(exp), pkt_text(act));
            stop_failed();
        end
    endtask

    task automatic check_req(string name, imem_req_t exp, imem_req_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected valid=%b pc=%h, actual valid=%b pc=%h",
                     name, exp.valid, exp.pc, act.valid, act.pc);
            stop_failed();
        end
    endtask

    // Plain words where branches sat leave stale BTB entries behind
    task automatic rewrite_region(int base);
        int         idx;
        logic [5:0] op;
        for (int i = 0; i < 16; i++) begin
            idx = (base + i) % 256;
            op  = prog[idx][31:26];
            if (op == OP_B || op == OP_BL) begin
                prog[idx] = {6'b000010, prog[idx][25:0]};
            end else if (rand_word() % 4 == 0) begin
                prog[idx] = gen_word();
            end
        end
    endtask

    // Called right after the rising edge to see the values sampled there
    task automatic observe_edge();
        fetch_pkt_t exp;
        imem_req_t  first;
        logic       req_fire;
        logic       ret_taken;
        req_fire = imem_req.valid && req_ready;
        dec_fire = dec_valid && dec_ready;
        if (held) begin
            check_req("req_hold", held_req, imem_req);
        end
        held     = imem_req.valid && !req_ready;
        held_req = imem_req;
        if (req_fire && pend) begin
            $display("ERROR: a second memory request was issued while one was outstanding");
            stop_failed();
        end
        if (imem_rsp.valid) begin
            pend    = 1'b0;
            rsp_cnt = rsp_cnt + 1;
        end
        if (req_fire) begin
            if (!first_seen) begin
                first.valid = 1'b1;
                first.pc    = BASE_PC;
                check_req("first_req", first, imem_req);
                first_seen = 1'b1;
            end
            pend      = 1'b1;
            pend_word = prog[imem_req.pc[9:2]];
            pend_cnt  = 1 + int'(rand_word() % 3);
        end
        if (dec_valid && rsp_cnt == 0) begin
            $display("ERROR: a packet reached decode before any memory response");
            stop_failed();
        end
        if (dec_fire) begin
            exp.pc              = model_pc;
            exp.inst            = prog[model_pc[9:2]];
            ret_taken           = is_return(exp.inst) && model_ras.size() != 0;
            exp.next.pc         = arch_next(model_pc, exp.inst);
            exp.next.is_predict = ret_taken || predicted_by_btb(model_pc, exp.next.pc);
            check_pkt(after_redir ? "redirect_target" : "stream", exp, dec_pkt);
            train_btb(model_pc, exp.inst, ret_taken);
            update_ras(model_pc, exp.inst);
            model_pc    = exp.next.pc;
            after_redir = 1'b0;
            pkt_cnt     = pkt_cnt + 1;
            stall       = 0;
        end else begin
            stall = stall + 1;
        end
    endtask

    task automatic drive_inputs();
        int base;
        be_redirect = '0;
        imem_rsp    = '0;
        if (dut0.u_fetch2_check.props0.err_cnt != 0) begin
            $display("ERROR: a bound property on the fetch stage 2 outputs failed");
            stop_failed();
        end
        if (dec_fire && rand_word() % 60 == 0) begin
            base              = int'(rand_word() % 256);
            be_redirect.valid = 1'b1;
            be_redirect.pc    = BASE_PC + u32_t'(base * 4);
            rewrite_region(base);
            model_pc    = be_redirect.pc;
            model_ras.delete();
            held        = 1'b0;
            after_redir = 1'b1;
        end
        if (pend && pend_cnt > 0) begin
            pend_cnt = pend_cnt - 1;
            if (pend_cnt == 0) begin
                imem_rsp.valid = 1'b1;
                imem_rsp.inst  = pend_word;
            end
        end
        req_ready = (rand_word() % 4) != 0;
        dec_ready = (rand_word() % 10) < 7;
    endtask

    initial begin
        imem_req_t idle;
        rst_n       = 1'b0;
        req_ready   = 1'b0;
        imem_rsp    = '0;
        dec_ready   = 1'b0;
        be_redirect = '0;
        seed        = 32'd94333;
        model_pc    = BASE_PC;
        pend        = 1'b0;
        pend_cnt    = 0;
        held        = 1'b0;
        first_seen  = 1'b0;
        after_redir = 1'b0;
        dec_fire    = 1'b0;
        pkt_cnt     = 0;
        rsp_cnt     = 0;
        stall       = 0;
        for (int i = 0; i < BTB_N; i++) begin
            model_btb_valid[i] = 1'b0;
        end
        for (int i = 0; i < 256; i++) begin
            prog[i] = gen_word();
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n      = 1'b1;
        idle.valid = 1'b0;
        idle.pc    = BASE_PC;
        check_req("reset_req", idle, imem_req);
        if (dec_valid !== 1'b0) begin
            $display("ERROR: decode valid was high right after reset");
            stop_failed();
        end
        while (pkt_cnt < NUM_PKTS) begin
            @(posedge clk);
            observe_edge();
            if (stall > STALL_MAX) begin
                $display("ERROR: timeout, no packet reached decode for %0d cycles", STALL_MAX);
                stop_failed();
            end
            @(negedge clk);
            drive_inputs();
        end
        if (dut0.u_fetch2_check.props0.err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("ERROR: a bound property on the fetch stage 2 outputs failed");
            stop_failed();
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+common
common/fe_pkg.sv
bpred/btb.sv
bpred/ras.sv
design/pc_gen.sv
design/fetch2_check.sv
design/fetch_top.sv
tb/fetch_props.sv
tb/fetch_tb.sv

// ==== Makefile ====
TOP := fetch_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

lint:
	verilator --lint-only --timing --assert -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
